/* bm_macros.svh */
`ifndef BM_MACROS_SVH
`define BM_MACROS_SVH

// ---------------------------------------------------------------------------
// stream and feature-map sizes
// ---------------------------------------------------------------------------
`define BM_AXI_DW       32      // read beat width
`define BM_FM_DEPTH     1024    // words per feature-map buffer
`define BM_FM_AW        10

// ---------------------------------------------------------------------------
// filter sizes
// ---------------------------------------------------------------------------
`define BM_FILTER_DEPTH 512
`define BM_FILTER_AW    9
`define BM_TAPS         9       // 3x3 kernel
`define BM_LANES        4       // one beat byte per lane

// layer channel count width
`define BM_W_CHANNEL    7

`endif

/* bm_pkg.sv */
`default_nettype none

`include "bm_macros.svh"

package bm_pkg;

    // stream side
    typedef logic [`BM_AXI_DW-1:0] beat_t;

    // feature map words are as wide as a beat
    typedef logic [`BM_AXI_DW-1:0] fm_word_t;
    typedef logic [`BM_FM_AW-1:0]  fm_addr_t;

    // kernel word, tap 0 sits in the low byte
    typedef logic [`BM_TAPS*8-1:0]   filter_word_t;
    typedef logic [`BM_FILTER_AW-1:0] filter_addr_t;
    typedef logic [3:0]              tap_idx_t;     // 0 .. 8

    typedef logic [`BM_W_CHANNEL-1:0] chan_t;

endpackage

`default_nettype wire

/* bm_dpram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bm_macros.svh"

module bm_dpram #(
    parameter int  DEPTH     = `BM_FM_DEPTH,
    parameter type payload_t = bm_pkg::fm_word_t
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];
    payload_t rd_q = '0;    // read register starts at zero

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // registered read, holds between requests
    always_ff @(posedge clk) begin
        if (rd_en) rd_q <= mem[rd_addr];
    end

    assign rd_data = rd_q;

endmodule

`default_nettype wire

/* filter_loader.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bm_macros.svh"

module filter_loader (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 q_load_filter,
    input  bm_pkg::chan_t        q_channel,
    input  bm_pkg::beat_t        read_data,
    input  logic                 read_data_vld,
    input  logic                 fb_req,
    input  bm_pkg::filter_addr_t fb_addr,
    output bm_pkg::filter_word_t fb_data0,
    output bm_pkg::filter_word_t fb_data1,
    output bm_pkg::filter_word_t fb_data2,
    output bm_pkg::filter_word_t fb_data3,
    output logic                 fb_req_possible,
    output logic                 o_load_filter_done
);

    import bm_pkg::*;

    localparam tap_idx_t LAST_TAP = tap_idx_t'(`BM_TAPS - 1);

    // ------------------------------------------------------------------------
    // start detect and tap position
    // ------------------------------------------------------------------------
    logic         load_d;
    logic         armed;
    tap_idx_t     tap;
    logic         load_rise;
    logic         beat_vld;
    logic         first_beat;
    tap_idx_t     tap_use;
    logic         commit;
    logic         commit_d;
    filter_addr_t wr_addr;
    filter_addr_t last_addr;
    logic         last_write;
    filter_word_t acc [`BM_LANES];
    filter_word_t rd_word [`BM_LANES];

    assign load_rise  = q_load_filter & ~load_d;
    assign beat_vld   = q_load_filter & read_data_vld;
    assign first_beat = (armed | load_rise) & beat_vld;     // edge cycle counts as armed
    assign tap_use    = first_beat ? '0 : tap;
    assign commit     = beat_vld && (tap_use == LAST_TAP);

    // four lanes per channel
    assign last_addr  = {q_channel, 2'b00} - 1'b1;
    assign last_write = commit_d && (wr_addr == last_addr);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d   <= 1'b0;
            armed    <= 1'b0;
            tap      <= '0;
            commit_d <= 1'b0;
            wr_addr  <= '0;
        end else begin
            load_d   <= q_load_filter;
            commit_d <= commit;
            if (first_beat)     armed <= 1'b0;
            else if (load_rise) armed <= 1'b1;
            if (beat_vld) tap <= (tap_use == LAST_TAP) ? '0 : tap_use + 1'b1;

            if (first_beat) begin
                wr_addr <= '0;
            end else if (commit_d) begin
                wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 1'b1;   // wrap
            end
        end
    end

    // byte k of the beat is tap of lane k
    always_ff @(posedge clk) begin
        if (beat_vld) begin
            for (int k = 0; k < `BM_LANES; k++) begin
                acc[k][8*tap_use +: 8] <= read_data[8*k +: 8];
            end
        end
    end

    // ------------------------------------------------------------------------
    // ready level and done pulse
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fb_req_possible    <= 1'b0;
            o_load_filter_done <= 1'b0;
        end else begin
            o_load_filter_done <= last_write & ~load_rise;
            if (load_rise)       fb_req_possible <= 1'b0;  // new load in progress
            else if (last_write) fb_req_possible <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // filter buffers, one per lane
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < `BM_LANES; g++) begin : g_lane
        bm_dpram #(
            .DEPTH     (`BM_FILTER_DEPTH),
            .payload_t (filter_word_t)
        ) u_filter_buf (
            .clk     (clk),
            .wr_en   (commit_d),
            .wr_addr (wr_addr),
            .wr_data (acc[g]),
            .rd_en   (fb_req),
            .rd_addr (fb_addr),
            .rd_data (rd_word[g])
        );
    end

    assign fb_data0 = rd_word[0];
    assign fb_data1 = rd_word[1];
    assign fb_data2 = rd_word[2];
    assign fb_data3 = rd_word[3];

endmodule

`default_nettype wire

/* fm_pingpong.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bm_macros.svh"

module fm_pingpong (
    input  logic             clk,
    input  logic             rstn,
    input  logic             q_load_ifm,
    input  logic             q_fm_buf_switch,
    input  bm_pkg::beat_t    read_data,
    input  logic             read_data_vld,
    input  logic             ofm_wr_en,
    input  bm_pkg::fm_addr_t ofm_wr_addr,
    input  bm_pkg::fm_word_t ofm_wr_data,
    input  logic             ifm_rd_en,
    input  bm_pkg::fm_addr_t ifm_rd_addr,
    output bm_pkg::fm_word_t ifm_rd_data
);

    import bm_pkg::*;

    localparam int FM_BUFS = 2;

    logic     in_sel;       // buffer index holding the input role
    logic     rd_sel;       // role seen by the last read
    logic     load_d;
    logic     load_rise;
    logic     axi_wr_en;
    fm_addr_t axi_wr_addr;
    fm_word_t axi_wr_data;
    logic     ofm_we;
    logic     buf_we    [FM_BUFS];
    fm_addr_t buf_waddr [FM_BUFS];
    fm_word_t buf_wdata [FM_BUFS];
    logic     buf_re    [FM_BUFS];
    fm_word_t buf_rdata [FM_BUFS];

    assign load_rise = q_load_ifm & ~load_d;
    assign ofm_we    = ofm_wr_en & ~q_load_ifm;     // engine locked out during a load

    // ------------------------------------------------------------------------
    // role pointer and AXI write register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_sel      <= 1'b0;
            rd_sel      <= 1'b0;
            load_d      <= 1'b0;
            axi_wr_en   <= 1'b0;
            axi_wr_addr <= '0;
        end else begin
            load_d    <= q_load_ifm;
            axi_wr_en <= q_load_ifm & read_data_vld;
            if (q_fm_buf_switch) in_sel <= ~in_sel;
            if (ifm_rd_en)       rd_sel <= in_sel;

            if (load_rise)      axi_wr_addr <= '0;
            else if (axi_wr_en) axi_wr_addr <= axi_wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (q_load_ifm && read_data_vld) axi_wr_data <= read_data;
    end

    // ------------------------------------------------------------------------
    // port steering
    // ------------------------------------------------------------------------
    for (genvar b = 0; b < FM_BUFS; b++) begin : g_fm
        logic is_in;

        assign is_in        = (in_sel == b[0]);
        assign buf_we[b]    = is_in ? axi_wr_en   : ofm_we;
        assign buf_waddr[b] = is_in ? axi_wr_addr : ofm_wr_addr;
        assign buf_wdata[b] = is_in ? axi_wr_data : ofm_wr_data;
        assign buf_re[b]    = is_in & ifm_rd_en;    // only the input role is read

        bm_dpram #(
            .DEPTH     (`BM_FM_DEPTH),
            .payload_t (fm_word_t)
        ) u_fm_buf (
            .clk     (clk),
            .wr_en   (buf_we[b]),
            .wr_addr (buf_waddr[b]),
            .wr_data (buf_wdata[b]),
            .rd_en   (buf_re[b]),
            .rd_addr (ifm_rd_addr),
            .rd_data (buf_rdata[b])
        );
    end

    assign ifm_rd_data = buf_rdata[rd_sel];

endmodule

`default_nettype wire

/* buffer_manager.sv */
`timescale 1ns/1ns
`default_nettype none

module buffer_manager (
    input  logic                 clk,
    input  logic                 rstn,

    // axi read stream
    input  bm_pkg::beat_t        read_data,
    input  logic                 read_data_vld,

    // layer controls
    input  bm_pkg::chan_t        q_channel,
    input  logic                 q_load_ifm,
    input  logic                 q_load_filter,
    input  logic                 q_fm_buf_switch,
    output logic                 o_load_filter_done,

    // filter read port
    output logic                 fb_req_possible,
    input  logic                 fb_req,
    input  bm_pkg::filter_addr_t fb_addr,
    output bm_pkg::filter_word_t fb_data0,
    output bm_pkg::filter_word_t fb_data1,
    output bm_pkg::filter_word_t fb_data2,
    output bm_pkg::filter_word_t fb_data3,

    // feature map ports
    input  logic                 ifm_rd_en,
    input  bm_pkg::fm_addr_t     ifm_rd_addr,
    output bm_pkg::fm_word_t     ifm_rd_data,
    input  logic                 ofm_wr_en,
    input  bm_pkg::fm_addr_t     ofm_wr_addr,
    input  bm_pkg::fm_word_t     ofm_wr_data
);

    filter_loader u_filter_loader (
        .clk                (clk),
        .rstn               (rstn),
        .q_load_filter      (q_load_filter),
        .q_channel          (q_channel),
        .read_data          (read_data),
        .read_data_vld      (read_data_vld),
        .fb_req             (fb_req),
        .fb_addr            (fb_addr),
        .fb_data0           (fb_data0),
        .fb_data1           (fb_data1),
        .fb_data2           (fb_data2),
        .fb_data3           (fb_data3),
        .fb_req_possible    (fb_req_possible),
        .o_load_filter_done (o_load_filter_done)
    );

    // the stream is shared, q_load_* decides which path takes a beat
    fm_pingpong u_fm_pingpong (
        .clk             (clk),
        .rstn            (rstn),
        .q_load_ifm      (q_load_ifm),
        .q_fm_buf_switch (q_fm_buf_switch),
        .read_data       (read_data),
        .read_data_vld   (read_data_vld),
        .ofm_wr_en       (ofm_wr_en),
        .ofm_wr_addr     (ofm_wr_addr),
        .ofm_wr_data     (ofm_wr_data),
        .ifm_rd_en       (ifm_rd_en),
        .ifm_rd_addr     (ifm_rd_addr),
        .ifm_rd_data     (ifm_rd_data)
    );

endmodule

`default_nettype wire

/* bm_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module bm_checker (
    input logic clk,
    input logic rstn,
    input logic q_load_filter,
    input logic fb_req_possible,
    input logic o_load_filter_done
);

    // ------------------------------------------------------------------------
    // filter ready and done
    // ------------------------------------------------------------------------

    // done comes together with the ready level
    a_done_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        o_load_filter_done |-> fb_req_possible
    ) else $error("o_load_filter_done high while fb_req_possible is low");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        o_load_filter_done |=> !o_load_filter_done     // one cycle only
    ) else $error("o_load_filter_done high for two cycles in a row");

    // a new filter load drops the ready level
    a_ready_clear: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(q_load_filter) |=> !fb_req_possible
    ) else $error("fb_req_possible still high after a new filter load started");

endmodule

`default_nettype wire

/* tb_buffer_manager.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bm_macros.svh"

module tb_buffer_manager;

    import bm_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RST_CYCLES   = 5;
    localparam int FM_BEATS     = 64;
    localparam int OFM_WRITES   = 48;
    localparam int WAIT_LIMIT   = 100;      // cycles to wait for the done pulse
    localparam int STREAM_LIMIT = 4000;     // cycles for one streamed load
    localparam int SIM_LIMIT_NS = 200_000;

    logic         clk = 1'b0;
    logic         rstn;
    beat_t        read_data;
    logic         read_data_vld;
    chan_t        q_channel;
    logic         q_load_ifm;
    logic         q_load_filter;
    logic         q_fm_buf_switch;
    logic         o_load_filter_done;
    logic         fb_req_possible;
    logic         fb_req;
    filter_addr_t fb_addr;
    filter_word_t fb_data0;
    filter_word_t fb_data1;
    filter_word_t fb_data2;
    filter_word_t fb_data3;
    logic         ifm_rd_en;
    fm_addr_t     ifm_rd_addr;
    fm_word_t     ifm_rd_data;
    logic         ofm_wr_en;
    fm_addr_t     ofm_wr_addr;
    fm_word_t     ofm_wr_data;

    // reference model
    filter_word_t filt_model [`BM_LANES][`BM_FILTER_DEPTH];
    fm_word_t     fm_model   [2][`BM_FM_DEPTH];
    logic         in_role;                  // buffer index with the input role
    fm_addr_t     ofm_addrs [$];
    logic [31:0]  lcg_state;
    int           done_cnt = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    buffer_manager u_dut (
        .clk                (clk),
        .rstn               (rstn),
        .read_data          (read_data),
        .read_data_vld      (read_data_vld),
        .q_channel          (q_channel),
        .q_load_ifm         (q_load_ifm),
        .q_load_filter      (q_load_filter),
        .q_fm_buf_switch    (q_fm_buf_switch),
        .o_load_filter_done (o_load_filter_done),
        .fb_req_possible    (fb_req_possible),
        .fb_req             (fb_req),
        .fb_addr            (fb_addr),
        .fb_data0           (fb_data0),
        .fb_data1           (fb_data1),
        .fb_data2           (fb_data2),
        .fb_data3           (fb_data3),
        .ifm_rd_en          (ifm_rd_en),
        .ifm_rd_addr        (ifm_rd_addr),
        .ifm_rd_data        (ifm_rd_data),
        .ofm_wr_en          (ofm_wr_en),
        .ofm_wr_addr        (ofm_wr_addr),
        .ofm_wr_data        (ofm_wr_data)
    );

    bind buffer_manager bm_checker u_checker (
        .clk                (clk),
        .rstn               (rstn),
        .q_load_filter      (q_load_filter),
        .fb_req_possible    (fb_req_possible),
        .o_load_filter_done (o_load_filter_done)
    );

    always @(negedge clk) begin
        if (o_load_filter_done) done_cnt <= done_cnt + 1;  // pulse counter
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_filter(input string name, input filter_word_t got,
                                input filter_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_fm(input string name, input fm_word_t got, input fm_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // filter path
    // ------------------------------------------------------------------------
    task automatic load_filter(input chan_t ch);
        int          n_beats;
        int          i;
        int          cycles;
        int          done_before;
        int          w;
        int          t;
        logic [31:0] r;
        beat_t       b;
        n_beats     = `BM_TAPS * `BM_LANES * ch;
        done_before = done_cnt;
        @(posedge clk);
        q_channel     <= ch;
        q_load_filter <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("fb_req_possible", fb_req_possible, 1'b0);  // cleared by the rising edge
        i = 0;
        cycles = 0;
        while (i < n_beats) begin
            @(posedge clk);
            r = next_rand();
            if (r[31:30] == 2'b00) begin
                read_data_vld <= 1'b0;      // gap
            end else begin
                b = next_rand();
                read_data     <= b;
                read_data_vld <= 1'b1;
                w = i / `BM_TAPS;
                t = i % `BM_TAPS;
                for (int k = 0; k < `BM_LANES; k++) begin
                    filt_model[k][w][8*t +: 8] = b[8*k +: 8];
                end
                i++;
            end
            cycles++;
            if (cycles > STREAM_LIMIT) begin
                $display("timeout: filter beats were not all sent in time");
                stop_with_failure();
            end
        end
        @(posedge clk);
        read_data_vld <= 1'b0;
        q_load_filter <= 1'b0;
        @(negedge clk);
        check_flag("o_load_filter_done before last write", done_cnt != done_before, 1'b0);
        cycles = 0;
        while (done_cnt == done_before) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: no o_load_filter_done pulse after the filter load");
                stop_with_failure();
            end
        end
        repeat (4) @(negedge clk);
        check_flag("o_load_filter_done single pulse", (done_cnt - done_before) == 1, 1'b1);
        check_flag("fb_req_possible", fb_req_possible, 1'b1);
    endtask

    task automatic read_filters(input chan_t ch);
        for (int a = 0; a < `BM_LANES * ch; a++) begin
            @(posedge clk);
            fb_req  <= 1'b1;
            fb_addr <= filter_addr_t'(a);
            @(posedge clk);
            fb_req  <= 1'b0;
            @(negedge clk);
            check_filter("fb_data0", fb_data0, filt_model[0][a]);
            check_filter("fb_data1", fb_data1, filt_model[1][a]);
            check_filter("fb_data2", fb_data2, filt_model[2][a]);
            check_filter("fb_data3", fb_data3, filt_model[3][a]);
        end
    endtask

    // ------------------------------------------------------------------------
    // feature-map path
    // ------------------------------------------------------------------------
    task automatic load_ifm(input int n);
        int          i;
        int          cycles;
        logic [31:0] r;
        beat_t       b;
        @(posedge clk);
        q_load_ifm <= 1'b1;
        i = 0;
        cycles = 0;
        while (i < n) begin
            @(posedge clk);
            r = next_rand();
            if (r[31:30] == 2'b00) begin
                read_data_vld <= 1'b0;
            end else begin
                b = next_rand();
                read_data     <= b;
                read_data_vld <= 1'b1;
                fm_model[in_role][i] = b;
                i++;
            end
            cycles++;
            if (cycles > STREAM_LIMIT) begin
                $display("timeout: feature-map beats were not all sent in time");
                stop_with_failure();
            end
        end
        @(posedge clk);
        read_data_vld <= 1'b0;
        q_load_ifm    <= 1'b0;
        repeat (2) @(posedge clk);  // beat to write is two cycles
    endtask

    task automatic read_fm(input fm_addr_t a);
        @(posedge clk);
        ifm_rd_en   <= 1'b1;
        ifm_rd_addr <= a;
        @(posedge clk);
        ifm_rd_en   <= 1'b0;
        @(negedge clk);
        check_fm("ifm_rd_data", ifm_rd_data, fm_model[in_role][a]);
    endtask

    task automatic write_ofm(input int n);
        int          j;
        int          cycles;
        logic [31:0] r;
        fm_addr_t    a;
        fm_word_t    d;
        j = 0;
        cycles = 0;
        while (j < n) begin
            @(posedge clk);
            r = next_rand();
            if (r[31:30] == 2'b00) begin
                ofm_wr_en <= 1'b0;
            end else begin
                r = next_rand();
                a = r[31:22];
                d = next_rand();
                ofm_wr_en   <= 1'b1;
                ofm_wr_addr <= a;
                ofm_wr_data <= d;
                fm_model[!in_role][a] = d;  // output role is the other buffer
                ofm_addrs.push_back(a);
                j++;
            end
            cycles++;
            if (cycles > STREAM_LIMIT) begin
                $display("timeout: output writes were not all sent in time");
                stop_with_failure();
            end
        end
        @(posedge clk);
        ofm_wr_en <= 1'b0;
    endtask

    task automatic switch_roles();
        @(posedge clk);
        q_fm_buf_switch <= 1'b1;
        @(posedge clk);
        q_fm_buf_switch <= 1'b0;
        in_role = !in_role;
    endtask

    initial begin
        #(SIM_LIMIT_NS);
        $display("timeout: simulation ran past its time limit");
        stop_with_failure();
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        chan_t       chan;
        lcg_state       = 32'h14dd_2ad9;
        in_role         = 1'b0;
        rstn            = 1'b0;
        read_data       = '0;
        read_data_vld   = 1'b0;
        q_channel       = '0;
        q_load_ifm      = 1'b0;
        q_load_filter   = 1'b0;
        q_fm_buf_switch = 1'b0;
        fb_req          = 1'b0;
        fb_addr         = '0;
        ifm_rd_en       = 1'b0;
        ifm_rd_addr     = '0;
        ofm_wr_en       = 1'b0;
        ofm_wr_addr     = '0;
        ofm_wr_data     = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("fb_req_possible", fb_req_possible, 1'b0);
        check_flag("o_load_filter_done", o_load_filter_done, 1'b0);
        check_filter("fb_data0", fb_data0, '0);
        check_fm("ifm_rd_data", ifm_rd_data, '0);

        r = next_rand();
        chan = chan_t'(r[31:30]) + 1'b1;   // 1 to 4 channels
        load_filter(chan);
        read_filters(chan);
        load_filter(chan);                  // same size, every word rewritten
        read_filters(chan);

        load_ifm(FM_BEATS);
        for (int a = 0; a < FM_BEATS; a++) read_fm(fm_addr_t'(a));
        write_ofm(OFM_WRITES);
        switch_roles();
        foreach (ofm_addrs[n]) read_fm(ofm_addrs[n]);
        switch_roles();
        for (int a = 0; a < FM_BEATS; a++) read_fm(fm_addr_t'(a));

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
bm_pkg.sv
bm_dpram.sv
filter_loader.sv
fm_pingpong.sv
buffer_manager.sv
bm_checker.sv
tb_buffer_manager.sv

/* Bender.yml */
package:
  name: buffer_manager

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bm_pkg.sv
      - bm_dpram.sv
      - filter_loader.sv
      - fm_pingpong.sv
      - buffer_manager.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - bm_checker.sv
      - tb_buffer_manager.sv
